// ==== flist.f ====
+incdir+src
src/id_stage_pkg.sv
src/operand_if.sv
src/register_file.sv
src/operand_forward.sv
src/operand_select.sv
src/id_ex_register.sv
src/id_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_id_stage.sv

// ==== src/id_ex_register.sv ====
/*
  ID/EX pipeline register for one payload type.
  Loads on a valid ID cycle; with BUBBLE_CLEAR set it clears when EX
  takes an empty slot, otherwise it holds.
*/
module id_ex_register
  #(
    parameter type PAYLOAD_T    = logic,
    parameter bit  BUBBLE_CLEAR = 1'b0
  )
  (
  input  logic     clk,
  input  logic     rst_n,

  // Stage handshake levels
  input  logic     id_valid_i,
  input  logic     ex_ready_i,

  input  PAYLOAD_T data_i,
  output PAYLOAD_T data_o
  );

  always_ff @(posedge clk, negedge rst_n)
  begin : pipe_reg
    if (!rst_n)
    begin
      data_o <= '0;
    end
    else if (id_valid_i)
    begin
      // New instruction into EX
      data_o <= data_i;
    end
    else if (BUBBLE_CLEAR && ex_ready_i)
    begin
      // EX moves on with nothing behind it
      data_o <= '0;
    end
    // EX stalled, keep contents
  end

endmodule

// ==== src/id_stage.sv ====
/*
  Operand side of the decode stage.
  Register file, per-operand forwarding, operand selection and ID/EX registers.
  Select codes and use flags come straight from the ports.
*/
`include "id_stage_cfg.svh"

module id_stage
  (
  input  logic                    clk,
  input  logic                    rst_n,

  input  id_stage_pkg::word_t     instr_i,
  input  id_stage_pkg::word_t     pc_i,
  input  logic                    is_compressed_i,

  // Register use flags
  input  logic                    rega_used_i,
  input  logic                    regb_used_i,
  input  logic                    regc_used_i,

  // Operand selection
  input  id_stage_pkg::op_a_sel_e op_a_sel_i,
  input  id_stage_pkg::op_b_sel_e op_b_sel_i,
  input  id_stage_pkg::imm_sel_e  imm_sel_i,
  input  logic                    scalar_repl_i,
  input  id_stage_pkg::vec_mode_e vec_mode_i,

  // Writeback control of this instruction
  input  logic                    regfile_we_i,
  input  logic                    data_load_i,

  input  logic                    if_valid_i,
  input  logic                    ex_ready_i,

  // EX write port
  input  id_stage_pkg::reg_addr_t ex_waddr_i,
  input  logic                    ex_we_i,
  input  id_stage_pkg::word_t     ex_wdata_i,

  // WB write port
  input  id_stage_pkg::reg_addr_t wb_waddr_i,
  input  logic                    wb_we_i,
  input  id_stage_pkg::word_t     wb_wdata_i,

  output logic                    id_ready_o,
  output logic                    id_valid_o,

  // ID/EX outputs
  output id_stage_pkg::word_t     alu_operand_a_ex_o,
  output id_stage_pkg::word_t     alu_operand_b_ex_o,
  output id_stage_pkg::word_t     alu_operand_c_ex_o,
  output id_stage_pkg::word_t     regfile_rb_data_ex_o,
  output id_stage_pkg::reg_addr_t regfile_waddr_ex_o,
  output logic                    regfile_we_ex_o,
  output logic                    data_load_ex_o
  );

  import id_stage_pkg::*;

  operand_if   src_if [`ID_NUM_SRC] ();

  id_ex_ops_t  ops_id;
  id_ex_ops_t  ops_ex;
  id_ex_ctrl_t ctrl_id;
  id_ex_ctrl_t ctrl_ex;

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////

  assign src_if[0].raddr = instr_i[19:15];
  assign src_if[1].raddr = instr_i[24:20];
  assign src_if[2].raddr = instr_i[29:25];

  assign src_if[0].used  = rega_used_i;
  assign src_if[1].used  = regb_used_i;
  assign src_if[2].used  = regc_used_i;

  // Destination from rd
  assign ctrl_id.waddr   = instr_i[11:7];
  assign ctrl_id.we      = regfile_we_i;
  assign ctrl_id.load    = data_load_i;

  //////////////////////////////////////////////////
  // Register file and forwarding
  //////////////////////////////////////////////////

  register_file u_register_file
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .src        ( src_if     ),
    .ex_waddr_i ( ex_waddr_i ),
    .ex_we_i    ( ex_we_i    ),
    .ex_wdata_i ( ex_wdata_i ),
    .wb_waddr_i ( wb_waddr_i ),
    .wb_we_i    ( wb_we_i    ),
    .wb_wdata_i ( wb_wdata_i )
  );

  for (genvar g = 0; g < `ID_NUM_SRC; g++)
  begin : g_forward
    operand_forward u_operand_forward
    (
      .src        ( src_if[g]  ),
      .ex_waddr_i ( ex_waddr_i ),
      .ex_we_i    ( ex_we_i    ),
      .ex_wdata_i ( ex_wdata_i ),
      .wb_waddr_i ( wb_waddr_i ),
      .wb_we_i    ( wb_we_i    ),
      .wb_wdata_i ( wb_wdata_i ),
      .ctrl_ex_i  ( ctrl_ex    )
    );
  end

  operand_select u_operand_select
  (
    .instr_i         ( instr_i         ),
    .pc_i            ( pc_i            ),
    .is_compressed_i ( is_compressed_i ),
    .op_a_sel_i      ( op_a_sel_i      ),
    .op_b_sel_i      ( op_b_sel_i      ),
    .imm_sel_i       ( imm_sel_i       ),
    .scalar_repl_i   ( scalar_repl_i   ),
    .vec_mode_i      ( vec_mode_i      ),
    .src             ( src_if          ),
    .if_valid_i      ( if_valid_i      ),
    .ex_ready_i      ( ex_ready_i      ),
    .ops_o           ( ops_id          ),
    .id_ready_o      ( id_ready_o      ),
    .id_valid_o      ( id_valid_o      )
  );

  //////////////////////////////////////////////////
  // ID/EX pipeline registers
  //////////////////////////////////////////////////

  // Operands hold through a bubble
  id_ex_register #(.PAYLOAD_T(id_ex_ops_t), .BUBBLE_CLEAR(1'b0)) u_ops_reg
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .id_valid_i ( id_valid_o ),
    .ex_ready_i ( ex_ready_i ),
    .data_i     ( ops_id     ),
    .data_o     ( ops_ex     )
  );

  // Control clears so a bubble writes nothing
  id_ex_register #(.PAYLOAD_T(id_ex_ctrl_t), .BUBBLE_CLEAR(1'b1)) u_ctrl_reg
  (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .id_valid_i ( id_valid_o ),
    .ex_ready_i ( ex_ready_i ),
    .data_i     ( ctrl_id    ),
    .data_o     ( ctrl_ex    )
  );

  assign alu_operand_a_ex_o   = ops_ex.op_a;
  assign alu_operand_b_ex_o   = ops_ex.op_b;
  assign alu_operand_c_ex_o   = ops_ex.op_c;
  assign regfile_rb_data_ex_o = ops_ex.rb_data;
  assign regfile_waddr_ex_o   = ctrl_ex.waddr;
  assign regfile_we_ex_o      = ctrl_ex.we;
  assign data_load_ex_o       = ctrl_ex.load;

endmodule

// ==== src/id_stage_cfg.svh ====
/*
  Width and count macros for the decode stage operand path.
  Include wherever a width or a port count is needed.
*/
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

// Data word width
`define ID_XLEN 32

// Register index width
`define ID_REG_ADDR_W 5

// Source operands rs1, rs2, rs3
`define ID_NUM_SRC 3

// Architectural registers, x0 included
`define ID_NUM_REGS 32

`endif

// ==== src/id_stage_pkg.sv ====
/*
  Types shared by the decode stage operand path.
  Data words, register indices, mux select codes and ID/EX payloads.
*/
`include "id_stage_cfg.svh"

package id_stage_pkg;

  typedef logic [`ID_XLEN-1:0]       word_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // Forwarding source per operand
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REGA_OR_FWD = 2'b00,
    OP_A_CURRPC      = 2'b01,
    OP_A_ZIMM        = 2'b10,
    OP_A_ZERO        = 2'b11
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REGB_OR_FWD = 2'b00,
    OP_B_REGC_OR_FWD = 2'b01,
    OP_B_IMM         = 2'b10
  } op_b_sel_e;

  typedef enum logic [1:0] {
    IMM_I      = 2'b00,
    IMM_S      = 2'b01,
    IMM_U      = 2'b10,
    IMM_PCINCR = 2'b11
  } imm_sel_e;

  // Scalar replication width
  typedef enum logic {
    VEC_MODE8  = 1'b0,
    VEC_MODE16 = 1'b1
  } vec_mode_e;

  // Operands towards EX
  typedef struct packed {
    word_t op_a;
    word_t op_b;
    word_t op_c;
    word_t rb_data;
  } id_ex_ops_t;

  // Writeback control towards EX
  typedef struct packed {
    reg_addr_t waddr;
    logic      we;
    logic      load;
  } id_ex_ctrl_t;

endpackage

// ==== src/operand_forward.sv ====
/*
  Forwarding mux and load-use check for one source operand.
  Compares the operand address with both write ports and the registered EX control.
*/
module operand_forward
  (
  operand_if.forward                src,

  // EX write port
  input  id_stage_pkg::reg_addr_t   ex_waddr_i,
  input  logic                      ex_we_i,
  input  id_stage_pkg::word_t       ex_wdata_i,

  // WB write port
  input  id_stage_pkg::reg_addr_t   wb_waddr_i,
  input  logic                      wb_we_i,
  input  id_stage_pkg::word_t       wb_wdata_i,

  // Control of the instruction now in EX
  input  id_stage_pkg::id_ex_ctrl_t ctrl_ex_i
  );

  import id_stage_pkg::*;

  fw_sel_e fw_sel;
  logic    addr_nz;
  logic    ex_hit;
  logic    wb_hit;

  // x0 never forwarded
  assign addr_nz = (src.raddr != '0);
  assign ex_hit  = ex_we_i & (ex_waddr_i == src.raddr) & addr_nz;
  assign wb_hit  = wb_we_i & (wb_waddr_i == src.raddr) & addr_nz;

  // Youngest result first
  always_comb
  begin : fw_sel_logic
    if (ex_hit)
      fw_sel = SEL_FW_EX;
    else if (wb_hit)
      fw_sel = SEL_FW_WB;
    else
      fw_sel = SEL_REGFILE;
  end

  always_comb
  begin : fw_mux
    case (fw_sel)
      SEL_FW_EX: src.fwd_data = ex_wdata_i;
      SEL_FW_WB: src.fwd_data = wb_wdata_i;
      default:   src.fwd_data = src.rdata;
    endcase
  end

  // Load in EX targets this operand, data not there yet
  assign src.hazard = src.used & ctrl_ex_i.load & ctrl_ex_i.we &
                      (ctrl_ex_i.waddr == src.raddr) & addr_nz;

endmodule

// ==== src/operand_if.sv ====
/*
  One source operand as it passes from register file to forwarding to selection.
  One instance per operand, indexed rs1, rs2, rs3.
*/
interface operand_if;
  import id_stage_pkg::*;

  // Read address and use flag from the instruction
  reg_addr_t raddr;
  logic      used;

  // Register file read data
  word_t     rdata;

  // Value after forwarding, plus load-use flag
  word_t     fwd_data;
  logic      hazard;

  modport regfile (input raddr, output rdata);

  modport forward (
    input  raddr,
    input  used,
    input  rdata,
    output fwd_data,
    output hazard
  );

  modport select (input fwd_data, input hazard);

endinterface

// ==== src/operand_select.sv ====
/*
  Immediate extraction and the operand A, B and C muxes of the decode stage.
  Also merges the per-operand hazards into the stage ready and valid levels.
*/
`include "id_stage_cfg.svh"

module operand_select
  (
  input  id_stage_pkg::word_t      instr_i,
  input  id_stage_pkg::word_t      pc_i,
  input  logic                     is_compressed_i,

  // Select codes in place of the decoder
  input  id_stage_pkg::op_a_sel_e  op_a_sel_i,
  input  id_stage_pkg::op_b_sel_e  op_b_sel_i,
  input  id_stage_pkg::imm_sel_e   imm_sel_i,
  input  logic                     scalar_repl_i,
  input  id_stage_pkg::vec_mode_e  vec_mode_i,

  // Forwarded operands rs1, rs2, rs3
  operand_if.select                src [`ID_NUM_SRC],

  input  logic                     if_valid_i,
  input  logic                     ex_ready_i,

  output id_stage_pkg::id_ex_ops_t ops_o,
  output logic                     id_ready_o,
  output logic                     id_valid_o
  );

  import id_stage_pkg::*;

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_u_type;
  word_t imm_z_type;
  word_t immediate_b;
  word_t operand_b;
  word_t operand_b_vec;
  logic [`ID_NUM_SRC-1:0] hazard_vec;

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // Sign extended from bit 31
  assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = word_t'({instr_i[31:12], 12'b0});
  // rs1 field as unsigned value
  assign imm_z_type = {{(`ID_XLEN-`ID_REG_ADDR_W){1'b0}}, instr_i[19:15]};

  always_comb
  begin : immediate_mux
    case (imm_sel_i)
      IMM_S:      immediate_b = imm_s_type;
      IMM_U:      immediate_b = imm_u_type;
      IMM_PCINCR: immediate_b = is_compressed_i ? word_t'(2) : word_t'(4);
      default:    immediate_b = imm_i_type;
    endcase
  end

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb
  begin : operand_a_mux
    case (op_a_sel_i)
      OP_A_CURRPC: ops_o.op_a = pc_i;
      OP_A_ZIMM:   ops_o.op_a = imm_z_type;
      OP_A_ZERO:   ops_o.op_a = '0;
      default:     ops_o.op_a = src[0].fwd_data;
    endcase
  end

  // Operand C is plain forwarded rs3
  assign ops_o.op_c = src[2].fwd_data;

  always_comb
  begin : operand_b_mux
    case (op_b_sel_i)
      OP_B_REGC_OR_FWD: operand_b = ops_o.op_c;
      OP_B_IMM:         operand_b = immediate_b;
      default:          operand_b = src[1].fwd_data;
    endcase
  end

  // Low byte or halfword repeated across the word
  assign operand_b_vec = (vec_mode_i == VEC_MODE8) ? {(`ID_XLEN/8){operand_b[7:0]}}
                                                   : {(`ID_XLEN/16){operand_b[15:0]}};
  assign ops_o.op_b    = scalar_repl_i ? operand_b_vec : operand_b;

  // rs2 value before the B mux, store data path
  assign ops_o.rb_data = src[1].fwd_data;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  for (genvar g = 0; g < `ID_NUM_SRC; g++)
  begin : g_hazard
    assign hazard_vec[g] = src[g].hazard;
  end

  // Any operand waiting on a load stalls the stage
  assign id_ready_o = ~(|hazard_vec) & ex_ready_i;
  assign id_valid_o = id_ready_o & if_valid_i;

endmodule

// ==== src/register_file.sv ====
/*
  Register file with three asynchronous read ports and two synchronous write ports.
  EX port wins over WB on the same index; x0 reads zero and is never stored.
*/
`include "id_stage_cfg.svh"

module register_file
  (
  input  logic                    clk,
  input  logic                    rst_n,

  // Read ports rs1, rs2, rs3
  operand_if.regfile              src [`ID_NUM_SRC],

  // EX write port, ALU result
  input  id_stage_pkg::reg_addr_t ex_waddr_i,
  input  logic                    ex_we_i,
  input  id_stage_pkg::word_t     ex_wdata_i,

  // WB write port, memory result
  input  id_stage_pkg::reg_addr_t wb_waddr_i,
  input  logic                    wb_we_i,
  input  id_stage_pkg::word_t     wb_wdata_i
  );

  import id_stage_pkg::*;

  // No storage behind x0
  word_t mem [1:`ID_NUM_REGS-1];

  always_ff @(posedge clk, negedge rst_n)
  begin : write_ports
    if (!rst_n)
    begin
      for (int i = 1; i < `ID_NUM_REGS; i++)
        mem[i] <= '0;
    end
    else
    begin
      for (int i = 1; i < `ID_NUM_REGS; i++)
      begin
        // EX first on a collision
        if (ex_we_i && (ex_waddr_i == reg_addr_t'(i)))
          mem[i] <= ex_wdata_i;
        else if (wb_we_i && (wb_waddr_i == reg_addr_t'(i)))
          mem[i] <= wb_wdata_i;
      end
    end
  end

  // Combinational reads, x0 forced to zero
  for (genvar g = 0; g < `ID_NUM_SRC; g++)
  begin : g_read
    assign src[g].rdata = (src[g].raddr == '0) ? '0 : mem[src[g].raddr];
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
  Clock and reset source for the decode stage testbench.
  Free-running clock, active-low reset held for a set number of cycles.
*/
module tb_clock_gen
  #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
  )
  (
  output logic clk_o,
  output logic rst_n_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin : clock_proc
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge
  initial
  begin : reset_proc
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== testbench/tb_id_stage.sv ====
/*
  Directed testbench for the decode stage operand path.
  Covers reset, register file, forwarding, operand muxes, load-use stall and back-pressure.
  A reference register model tracks every write made through the EX and WB ports.
*/
`include "id_stage_cfg.svh"

module tb_id_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import id_stage_pkg::*;

  localparam int PERIOD_NS     = 100;
  // About 52 cycles of tests, rounded up
  localparam int TEST_CYCLES   = 60;
  localparam int MARGIN_CYCLES = 40;

  logic clk;
  logic rst_n;

  word_t     instr_i;
  word_t     pc_i;
  logic      is_compressed_i;
  logic      rega_used_i;
  logic      regb_used_i;
  logic      regc_used_i;
  op_a_sel_e op_a_sel_i;
  op_b_sel_e op_b_sel_i;
  imm_sel_e  imm_sel_i;
  logic      scalar_repl_i;
  vec_mode_e vec_mode_i;
  logic      regfile_we_i;
  logic      data_load_i;
  logic      if_valid_i;
  logic      ex_ready_i;
  reg_addr_t ex_waddr_i;
  logic      ex_we_i;
  word_t     ex_wdata_i;
  reg_addr_t wb_waddr_i;
  logic      wb_we_i;
  word_t     wb_wdata_i;

  logic      id_ready_o;
  logic      id_valid_o;
  word_t     alu_operand_a_ex_o;
  word_t     alu_operand_b_ex_o;
  word_t     alu_operand_c_ex_o;
  word_t     regfile_rb_data_ex_o;
  reg_addr_t regfile_waddr_ex_o;
  logic      regfile_we_ex_o;
  logic      data_load_ex_o;

  // Expected register contents
  word_t reg_model [`ID_NUM_REGS];

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) u_clock_gen
  (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  id_stage UUT
  (
    .clk                  ( clk                  ),
    .rst_n                ( rst_n                ),
    .instr_i              ( instr_i              ),
    .pc_i                 ( pc_i                 ),
    .is_compressed_i      ( is_compressed_i      ),
    .rega_used_i          ( rega_used_i          ),
    .regb_used_i          ( regb_used_i          ),
    .regc_used_i          ( regc_used_i          ),
    .op_a_sel_i           ( op_a_sel_i           ),
    .op_b_sel_i           ( op_b_sel_i           ),
    .imm_sel_i            ( imm_sel_i            ),
    .scalar_repl_i        ( scalar_repl_i        ),
    .vec_mode_i           ( vec_mode_i           ),
    .regfile_we_i         ( regfile_we_i         ),
    .data_load_i          ( data_load_i          ),
    .if_valid_i           ( if_valid_i           ),
    .ex_ready_i           ( ex_ready_i           ),
    .ex_waddr_i           ( ex_waddr_i           ),
    .ex_we_i              ( ex_we_i              ),
    .ex_wdata_i           ( ex_wdata_i           ),
    .wb_waddr_i           ( wb_waddr_i           ),
    .wb_we_i              ( wb_we_i              ),
    .wb_wdata_i           ( wb_wdata_i           ),
    .id_ready_o           ( id_ready_o           ),
    .id_valid_o           ( id_valid_o           ),
    .alu_operand_a_ex_o   ( alu_operand_a_ex_o   ),
    .alu_operand_b_ex_o   ( alu_operand_b_ex_o   ),
    .alu_operand_c_ex_o   ( alu_operand_c_ex_o   ),
    .regfile_rb_data_ex_o ( regfile_rb_data_ex_o ),
    .regfile_waddr_ex_o   ( regfile_waddr_ex_o   ),
    .regfile_we_ex_o      ( regfile_we_ex_o      ),
    .data_load_ex_o       ( data_load_ex_o       )
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input word_t actual, input word_t expected, input string msg);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, msg, actual, expected);
      $display("TB FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_addr(input reg_addr_t actual, input reg_addr_t expected,
                            input string msg);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s, got %0d expected %0d", $time, msg, actual, expected);
      $display("TB FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string msg);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s, got %b expected %b", $time, msg, actual, expected);
      $display("TB FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // rd [11:7], rs1 [19:15], rs2 [24:20], rs3 [29:25]
  function automatic word_t make_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input reg_addr_t rs3);
    return {2'b00, rs3, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // EX first, then WB, then stored value; x0 always zero
  function automatic word_t forward_expect(input reg_addr_t rs,
                                           input logic ex_we, input reg_addr_t ex_addr,
                                           input word_t ex_data,
                                           input logic wb_we, input reg_addr_t wb_addr,
                                           input word_t wb_data);
    if (rs == 0)
      return '0;
    if (ex_we && ex_addr == rs)
      return ex_data;
    if (wb_we && wb_addr == rs)
      return wb_data;
    return reg_model[rs];
  endfunction

  task automatic model_write(input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
                             input logic wb_we, input reg_addr_t wb_addr, input word_t wb_data);
    if (ex_we && ex_addr != 0)
      reg_model[ex_addr] = ex_data;
    // Collision goes to EX
    if (wb_we && wb_addr != 0 && !(ex_we && ex_addr == wb_addr))
      reg_model[wb_addr] = wb_data;
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic init_inputs();
    instr_i         <= '0;
    pc_i            <= '0;
    is_compressed_i <= 1'b0;
    rega_used_i     <= 1'b1;
    regb_used_i     <= 1'b1;
    regc_used_i     <= 1'b1;
    op_a_sel_i      <= OP_A_REGA_OR_FWD;
    op_b_sel_i      <= OP_B_REGB_OR_FWD;
    imm_sel_i       <= IMM_I;
    scalar_repl_i   <= 1'b0;
    vec_mode_i      <= VEC_MODE8;
    regfile_we_i    <= 1'b0;
    data_load_i     <= 1'b0;
    if_valid_i      <= 1'b0;
    ex_ready_i      <= 1'b1;
    ex_waddr_i      <= '0;
    ex_we_i         <= 1'b0;
    ex_wdata_i      <= '0;
    wb_waddr_i      <= '0;
    wb_we_i         <= 1'b0;
    wb_wdata_i      <= '0;
    for (int i = 0; i < `ID_NUM_REGS; i++)
      reg_model[i] = '0;
  endtask

  // Present one instruction with IF valid
  task automatic drive_id(input word_t instr, input word_t pc, input logic compr,
                          input op_a_sel_e a_sel, input op_b_sel_e b_sel,
                          input imm_sel_e imm_sel, input logic repl, input vec_mode_e vmode);
    @(posedge clk);
    instr_i         <= instr;
    pc_i            <= pc;
    is_compressed_i <= compr;
    op_a_sel_i      <= a_sel;
    op_b_sel_i      <= b_sel;
    imm_sel_i       <= imm_sel;
    scalar_repl_i   <= repl;
    vec_mode_i      <= vmode;
    if_valid_i      <= 1'b1;
  endtask

  task automatic drive_reg_read(input reg_addr_t rs1, input reg_addr_t rs2,
                                input reg_addr_t rs3);
    drive_id(make_instr('0, rs1, rs2, rs3), '0, 1'b0, OP_A_REGA_OR_FWD,
             OP_B_REGB_OR_FWD, IMM_I, 1'b0, VEC_MODE8);
  endtask

  // ID/EX loads here, sample in the low phase
  task automatic end_id();
    @(posedge clk);
    if_valid_i   <= 1'b0;
    regfile_we_i <= 1'b0;
    data_load_i  <= 1'b0;
    ex_we_i      <= 1'b0;
    wb_we_i      <= 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reset_values();
    check_bit(regfile_we_ex_o, 1'b0, "reset regfile_we_ex_o");
    check_bit(data_load_ex_o, 1'b0, "reset data_load_ex_o");
    check_addr(regfile_waddr_ex_o, '0, "reset regfile_waddr_ex_o");
    check_word(alu_operand_a_ex_o, '0, "reset operand A");
    check_word(alu_operand_b_ex_o, '0, "reset operand B");
    check_word(alu_operand_c_ex_o, '0, "reset operand C");
    check_word(regfile_rb_data_ex_o, '0, "reset rb data");
  endtask

  task automatic regfile_round_trip();
    word_t val;
    // x0 gets a write too, which must not stick
    for (int r = 0; r <= 6; r++)
    begin
      val = $urandom();
      @(posedge clk);
      wb_we_i    <= 1'b1;
      wb_waddr_i <= reg_addr_t'(r);
      wb_wdata_i <= val;
      model_write(1'b0, '0, '0, 1'b1, reg_addr_t'(r), val);
    end
    @(posedge clk);
    wb_we_i <= 1'b0;
    for (int p = 0; p < 4; p++)
    begin
      reg_addr_t rs1;
      reg_addr_t rs2;
      rs1 = (p == 3) ? reg_addr_t'(0) : reg_addr_t'(2 * p + 1);
      rs2 = (p == 3) ? reg_addr_t'(6) : reg_addr_t'(2 * p + 2);
      drive_reg_read(rs1, rs2, '0);
      end_id();
      check_word(alu_operand_a_ex_o, reg_model[rs1], "regfile read rs1");
      check_word(alu_operand_b_ex_o, reg_model[rs2], "regfile read rs2 on B");
      check_word(regfile_rb_data_ex_o, reg_model[rs2], "regfile read rs2 raw");
    end
  endtask

  task automatic forward_case(input reg_addr_t rs1,
                              input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
                              input logic wb_we, input reg_addr_t wb_addr, input word_t wb_data,
                              input string msg);
    word_t expected;
    expected = forward_expect(rs1, ex_we, ex_addr, ex_data, wb_we, wb_addr, wb_data);
    drive_reg_read(rs1, '0, '0);
    ex_we_i    <= ex_we;
    ex_waddr_i <= ex_addr;
    ex_wdata_i <= ex_data;
    wb_we_i    <= wb_we;
    wb_waddr_i <= wb_addr;
    wb_wdata_i <= wb_data;
    end_id();
    check_word(alu_operand_a_ex_o, expected, msg);
    model_write(ex_we, ex_addr, ex_data, wb_we, wb_addr, wb_data);
  endtask

  task automatic forwarding_priority();
    forward_case(5, 1'b1, 5, $urandom(), 1'b1, 5, $urandom(), "EX wins over WB on rs1");
    forward_case(5, 1'b0, 0, '0, 1'b1, 5, $urandom(), "WB forward on rs1");
    forward_case(0, 1'b1, 0, $urandom(), 1'b1, 0, $urandom(), "x0 target gives zero");
  endtask

  task automatic operand_selection();
    word_t instr;
    word_t pc;
    word_t imm_i;
    instr = $urandom();
    pc    = $urandom();
    imm_i = sext12(instr[31:20]);
    drive_id(instr, pc, 1'b0, OP_A_CURRPC, OP_B_IMM, IMM_I, 1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_a_ex_o, pc, "operand A from PC");
    check_word(alu_operand_b_ex_o, imm_i, "I immediate");
    drive_id(instr, pc, 1'b0, OP_A_ZERO, OP_B_IMM, IMM_S, 1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_a_ex_o, '0, "operand A zero");
    check_word(alu_operand_b_ex_o, sext12({instr[31:25], instr[11:7]}), "S immediate");
    drive_id(instr, pc, 1'b0, OP_A_ZIMM, OP_B_IMM, IMM_U, 1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_a_ex_o, word_t'(instr[19:15]), "zero-extended rs1 immediate");
    check_word(alu_operand_b_ex_o, {instr[31:12], 12'h000}, "U immediate");
    drive_id(instr, pc, 1'b1, OP_A_ZERO, OP_B_IMM, IMM_PCINCR, 1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_b_ex_o, 32'd2, "PC increment compressed");
    drive_id(instr, pc, 1'b0, OP_A_ZERO, OP_B_IMM, IMM_PCINCR, 1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_b_ex_o, 32'd4, "PC increment full size");
    // Replication of the I immediate
    drive_id(instr, pc, 1'b0, OP_A_ZERO, OP_B_IMM, IMM_I, 1'b1, VEC_MODE8);
    end_id();
    check_word(alu_operand_b_ex_o, {4{imm_i[7:0]}}, "byte replication");
    drive_id(instr, pc, 1'b0, OP_A_ZERO, OP_B_IMM, IMM_I, 1'b1, VEC_MODE16);
    end_id();
    check_word(alu_operand_b_ex_o, {2{imm_i[15:0]}}, "halfword replication");
    drive_id(make_instr('0, 1, 2, 3), pc, 1'b0, OP_A_REGA_OR_FWD, OP_B_REGC_OR_FWD, IMM_I,
             1'b0, VEC_MODE8);
    end_id();
    check_word(alu_operand_b_ex_o, reg_model[3], "operand B from rs3");
    check_word(alu_operand_c_ex_o, reg_model[3], "operand C is rs3");
  endtask

  task automatic load_use_stall();
    // Load into x7, rs3 set so operand C has a value to hold
    drive_reg_read(1, 2, 3);
    instr_i      <= make_instr(7, 1, 2, 3);
    regfile_we_i <= 1'b1;
    data_load_i  <= 1'b1;
    // Consumer of x7 presented as the load enters EX
    drive_reg_read(7, 0, 0);
    regfile_we_i <= 1'b0;
    data_load_i  <= 1'b0;
    @(negedge clk);
    check_bit(regfile_we_ex_o, 1'b1, "load we in EX");
    check_bit(data_load_ex_o, 1'b1, "load in EX");
    check_addr(regfile_waddr_ex_o, 7, "load rd in EX");
    check_bit(id_ready_o, 1'b0, "load-use stall ready");
    check_bit(id_valid_o, 1'b0, "load-use stall valid");
    @(posedge clk);
    @(negedge clk);
    check_bit(regfile_we_ex_o, 1'b0, "bubble clears we");
    check_bit(data_load_ex_o, 1'b0, "bubble clears load");
    check_word(alu_operand_a_ex_o, reg_model[1], "bubble holds operand A");
    check_word(alu_operand_b_ex_o, reg_model[2], "bubble holds operand B");
    check_word(alu_operand_c_ex_o, reg_model[3], "bubble holds operand C");
    check_word(regfile_rb_data_ex_o, reg_model[2], "bubble holds rb data");
    check_bit(id_ready_o, 1'b1, "ready after bubble");
    end_id();
    check_word(alu_operand_a_ex_o, reg_model[7], "consumer issued after stall");
  endtask

  task automatic back_pressure_hold();
    drive_reg_read(3, 4, 5);
    instr_i      <= make_instr(9, 3, 4, 5);
    regfile_we_i <= 1'b1;
    data_load_i  <= 1'b1;
    // EX stalls in the same edge that loads this instruction
    @(posedge clk);
    ex_ready_i <= 1'b0;
    @(negedge clk);
    check_bit(regfile_we_ex_o, 1'b1, "we loaded before stall");
    check_bit(data_load_ex_o, 1'b1, "load loaded before stall");
    repeat (4)
    begin
      @(posedge clk);
      instr_i      <= $urandom();
      pc_i         <= $urandom();
      op_a_sel_i   <= op_a_sel_e'($urandom_range(3, 0));
      op_b_sel_i   <= op_b_sel_e'($urandom_range(2, 0));
      imm_sel_i    <= imm_sel_e'($urandom_range(3, 0));
      if_valid_i   <= $urandom_range(1, 0);
      regfile_we_i <= $urandom_range(1, 0);
      data_load_i  <= $urandom_range(1, 0);
      @(negedge clk);
      check_bit(id_ready_o, 1'b0, "ready low under back-pressure");
      check_bit(id_valid_o, 1'b0, "valid low under back-pressure");
      check_word(alu_operand_a_ex_o, reg_model[3], "operand A held");
      check_word(alu_operand_b_ex_o, reg_model[4], "operand B held");
      check_word(alu_operand_c_ex_o, reg_model[5], "operand C held");
      check_word(regfile_rb_data_ex_o, reg_model[4], "rb data held");
      check_addr(regfile_waddr_ex_o, 9, "rd held");
      check_bit(regfile_we_ex_o, 1'b1, "we held");
      check_bit(data_load_ex_o, 1'b1, "load held");
    end
    @(posedge clk);
    ex_ready_i <= 1'b1;
    end_id();
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin : main_seq
    void'($urandom(68));
    init_inputs();
    @(posedge rst_n);
    @(negedge clk);
    reset_values();
    regfile_round_trip();
    forwarding_priority();
    operand_selection();
    load_use_stall();
    back_pressure_hold();
    $display("TB PASSED");
    $finish;
  end

  initial
  begin : watchdog
    #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
    $display("Timeout: tests still running after %0d ns",
             (TEST_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
